// File: hw/rvPkg.sv
package rvPkg;

    localparam int wordWidth = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount = 2 ** regAddrWidth;

    typedef logic [wordWidth-1:0] word_t;
    typedef logic [regAddrWidth-1:0] regAddr_t;
    typedef logic [3:0] aluOp_t;
    typedef logic [2:0] writeLen_t;

    localparam word_t resetPc = 32'h0;

    // Base opcodes
    localparam logic [6:0] opLui = 7'b0110111;
    localparam logic [6:0] opJal = 7'b1101111;
    localparam logic [6:0] opLoad = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opOp = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;

    // ALU codes are {bit30, funct3}; EQ reuses an unused slot
    localparam aluOp_t aluOpAdd = 4'b0000;
    localparam aluOp_t aluOpEq = 4'b1001;
    localparam aluOp_t aluOpSlt = 4'b0010;
    localparam aluOp_t aluOpSltu = 4'b0011;

    typedef enum logic [1:0] {word, byteSigned, byteUnsigned, none} regWritePattern_t;
    typedef enum logic [1:0] {aluResult, upperImmediate, pcNext, mainMemory} regSource_t;
    typedef enum logic {register, immediate} aluSource_t;
    typedef enum logic {execute, loadWait} execState_t;

    typedef struct packed {
        aluOp_t aluOp;
        logic memWrite;
        logic memRead;
        writeLen_t writeLength;
        regWritePattern_t regWritePattern;
        logic regWriteEnable;
        aluSource_t aluSource;
        regSource_t regSource;
        logic isBranch;
        logic isJump;
    } control_t;

    // Byte extension applied on register write-back
    function automatic word_t applyPattern(regWritePattern_t pattern, word_t data);
        case (pattern)
            byteSigned: return {{24{data[7]}}, data[7:0]};
            byteUnsigned: return {24'b0, data[7:0]};
            default: return data;
        endcase
    endfunction

endpackage

// File: hw/memPortIf.sv
`timescale 1ns/1ps

interface memPortIf;
    logic req;
    rvPkg::word_t addr;
    rvPkg::word_t wrData;
    logic wrEnable;
    rvPkg::writeLen_t writeLength;
    logic grant;
    logic rdValid;
    rvPkg::word_t rdData;

    modport requester (
        output req, addr, wrData, wrEnable, writeLength,
        input grant, rdValid, rdData
    );

    modport arbiter (
        input req, addr, wrData, wrEnable, writeLength,
        output grant, rdValid, rdData
    );
endinterface

// File: hw/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  rvPkg::word_t    instr,
    output rvPkg::control_t control,
    output rvPkg::word_t    imm
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic isShift;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign isShift = (funct3[1:0] == 2'b01);

    always_comb begin
        control.aluOp = {1'b0, funct3};
        control.memWrite = 1'b0;
        control.memRead = 1'b0;
        control.writeLength = funct3;
        control.regWritePattern = rvPkg::word;
        control.regWriteEnable = 1'b0;
        control.aluSource = rvPkg::immediate;
        control.regSource = rvPkg::aluResult;
        control.isBranch = 1'b0;
        control.isJump = 1'b0;

        case (opcode)
            rvPkg::opLui: begin
                control.regWriteEnable = 1'b1;
                control.regSource = rvPkg::upperImmediate;
            end
            rvPkg::opJal: begin
                control.regWriteEnable = 1'b1;
                control.regSource = rvPkg::pcNext;
                control.isJump = 1'b1;
            end
            rvPkg::opLoad: begin
                control.aluOp = rvPkg::aluOpAdd;
                control.memRead = 1'b1;
                control.regWriteEnable = 1'b1;
                control.regSource = rvPkg::mainMemory;
                // LH/LHU fall through as word loads
                if (funct3 == 3'b100) begin
                    control.regWritePattern = rvPkg::byteUnsigned;
                end else if (funct3 == 3'b000) begin
                    control.regWritePattern = rvPkg::byteSigned;
                end
            end
            rvPkg::opStore: begin
                control.aluOp = rvPkg::aluOpAdd;
                control.memWrite = 1'b1;
                control.regWritePattern = rvPkg::none;
            end
            rvPkg::opOpImm: begin
                // Only SRAI carries bit30 into the ALU code
                control.aluOp = {funct3 == 3'b101 && funct7[5], funct3};
                control.regWriteEnable = 1'b1;
            end
            rvPkg::opOp: begin
                control.aluOp = {funct7[5], funct3};
                control.aluSource = rvPkg::register;
                control.regWriteEnable = 1'b1;
            end
            rvPkg::opBranch: begin
                control.aluSource = rvPkg::register;
                control.regWritePattern = rvPkg::none;
                control.isBranch = 1'b1;
                if (!funct3[2]) begin
                    control.aluOp = rvPkg::aluOpEq;
                end else if (funct3[1]) begin
                    control.aluOp = rvPkg::aluOpSltu;
                end else begin
                    control.aluOp = rvPkg::aluOpSlt;
                end
            end
            default: begin
                control.regWritePattern = rvPkg::none;
            end
        endcase
    end

    // Immediate per format
    always_comb begin
        case (opcode)
            rvPkg::opOpImm: imm = isShift ? {27'b0, instr[24:20]} : {{20{instr[31]}}, instr[31:20]};
            rvPkg::opLoad: imm = {{20{instr[31]}}, instr[31:20]};
            rvPkg::opStore: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            rvPkg::opBranch: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            rvPkg::opJal: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            rvPkg::opLui: imm = {instr[31:12], 12'h000};
            default: imm = '0;
        endcase
    end
endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  rvPkg::aluOp_t op,
    input  rvPkg::word_t  left,
    input  rvPkg::word_t  right,
    output rvPkg::word_t  result
);
    logic [4:0] shamt;

    assign shamt = right[4:0];

    always_comb begin
        case (op)
            rvPkg::aluOpAdd: result = left + right;
            4'b1000: result = left - right;
            4'b0001: result = left << shamt;
            rvPkg::aluOpSlt: result = rvPkg::word_t'($signed(left) < $signed(right));
            rvPkg::aluOpSltu: result = rvPkg::word_t'(left < right);
            4'b0100: result = left ^ right;
            4'b0101: result = left >> shamt;
            // Arithmetic shift right
            4'b1101: result = $signed(left) >>> shamt;
            4'b0110: result = left | right;
            4'b0111: result = left & right;
            rvPkg::aluOpEq: result = rvPkg::word_t'(left == right);
            default: result = '0;
        endcase
    end
endmodule

// File: hw/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                    clk,
    input  logic                    rstN,
    input  rvPkg::regAddr_t         rdAddrA,
    input  rvPkg::regAddr_t         rdAddrB,
    output rvPkg::word_t            dataOutA,
    output rvPkg::word_t            dataOutB,
    input  logic                    wrEnable,
    input  rvPkg::regAddr_t         wrAddr,
    input  rvPkg::word_t            wrData,
    input  rvPkg::regWritePattern_t writePattern
);
    rvPkg::word_t regs [rvPkg::regCount];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < rvPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEnable && wrAddr != '0 && writePattern != rvPkg::none) begin
            // x0 never written
            regs[wrAddr] <= rvPkg::applyPattern(writePattern, wrData);
        end
    end

    assign dataOutA = regs[rdAddrA];
    assign dataOutB = regs[rdAddrB];
endmodule

// File: hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  logic            clk,
    input  logic            rstN,
    memPortIf.requester     dataPort,
    input  logic            instrValid,
    input  rvPkg::word_t    instr,
    input  rvPkg::word_t    instrPc,
    output logic            instrTake,
    output logic            redirect,
    output rvPkg::word_t    redirectPc,
    output logic            retireValid,
    output rvPkg::word_t    retirePc,
    output rvPkg::regAddr_t retireRd,
    output logic            retireWrite,
    output rvPkg::word_t    retireData
);
    rvPkg::control_t ctrl;
    rvPkg::execState_t state;
    rvPkg::word_t imm;
    rvPkg::word_t dataOutA;
    rvPkg::word_t dataOutB;
    rvPkg::word_t aluRight;
    rvPkg::word_t aluResult;
    rvPkg::word_t pcNext;
    rvPkg::word_t wbData;
    rvPkg::regAddr_t rd;
    rvPkg::regAddr_t rs1;
    rvPkg::regAddr_t rs2;
    logic isMem;
    logic active;
    logic taken;
    logic regWrite;

    assign rd = instr[11:7];
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];

    controlUnit controlUnit_i (.instr(instr), .control(ctrl), .imm(imm));

    // rs2 on port a, rs1 on port b
    registerFile registerFile_i (
        .clk(clk),
        .rstN(rstN),
        .rdAddrA(rs2),
        .rdAddrB(rs1),
        .dataOutA(dataOutA),
        .dataOutB(dataOutB),
        .wrEnable(regWrite),
        .wrAddr(rd),
        .wrData(wbData),
        .writePattern(ctrl.regWritePattern)
    );

    assign aluRight = (ctrl.aluSource == rvPkg::immediate) ? imm : dataOutA;

    alu alu_i (.op(ctrl.aluOp), .left(dataOutB), .right(aluRight), .result(aluResult));

    assign pcNext = instrPc + 32'd4;

    always_comb begin
        case (ctrl.regSource)
            rvPkg::aluResult: wbData = aluResult;
            rvPkg::upperImmediate: wbData = imm;
            rvPkg::pcNext: wbData = pcNext;
            default: wbData = dataPort.rdData;
        endcase
    end

    // Load/store path
    assign isMem = ctrl.memRead || ctrl.memWrite;
    assign active = (state == rvPkg::execute) && instrValid;
    assign dataPort.req = active && isMem;
    assign dataPort.addr = aluResult;
    assign dataPort.wrData = dataOutA;
    assign dataPort.wrEnable = ctrl.memWrite;
    assign dataPort.writeLength = ctrl.writeLength;

    // Loads leave the buffer only once read data is back
    assign instrTake = (active && (!isMem || (ctrl.memWrite && dataPort.grant)))
        || (state == rvPkg::loadWait && dataPort.rdValid);
    assign regWrite = instrTake && ctrl.regWriteEnable;

    // funct3[0] inverts for BNE, BGE, BGEU
    assign taken = ctrl.isBranch && (aluResult[0] ^ instr[12]);
    assign redirect = active && (ctrl.isJump || taken);
    assign redirectPc = instrPc + imm;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= rvPkg::execute;
        end else begin
            case (state)
                rvPkg::execute: begin
                    if (dataPort.req && dataPort.grant && ctrl.memRead) begin
                        state <= rvPkg::loadWait;
                    end
                end
                default: begin
                    if (dataPort.rdValid) begin
                        state <= rvPkg::execute;
                    end
                end
            endcase
        end
    end

    assign retireValid = instrTake;
    assign retirePc = instrPc;
    assign retireRd = rd;
    assign retireWrite = ctrl.regWriteEnable && (rd != '0);
    assign retireData = rvPkg::applyPattern(ctrl.regWritePattern, wbData);

    // A granted write from the arbiter never lands in the register file
    storeNoRegWrite: assert property (@(posedge clk) disable iff (!rstN)
        (dataPort.grant && dataPort.wrEnable) |-> !regWrite);
endmodule

// File: hw/fetchUnit.sv
`timescale 1ns/1ps

module fetchUnit (
    input  logic         clk,
    input  logic         rstN,
    memPortIf.requester  fetchPort,
    output logic         instrValid,
    output rvPkg::word_t instr,
    output rvPkg::word_t instrPc,
    input  logic         instrTake,
    input  logic         redirect,
    input  rvPkg::word_t redirectPc
);
    rvPkg::word_t pc;
    logic running;
    logic bufValid;
    logic inFlight;
    logic fetchGranted;
    logic fetchReturn;

    // Refill as soon as the buffer is empty or being taken
    assign fetchPort.req = running && (!bufValid || instrTake) && !inFlight;
    assign fetchPort.addr = pc;
    assign fetchPort.wrData = '0;
    assign fetchPort.wrEnable = 1'b0;
    assign fetchPort.writeLength = 3'b010;

    assign fetchGranted = fetchPort.req && fetchPort.grant;
    assign fetchReturn = inFlight && fetchPort.rdValid;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= rvPkg::resetPc;
            running <= 1'b0;
            bufValid <= 1'b0;
            inFlight <= 1'b0;
        end else begin
            running <= 1'b1;
            if (redirect) begin
                // Drop buffer and anything still outstanding
                pc <= redirectPc;
                bufValid <= 1'b0;
                inFlight <= 1'b0;
            end else begin
                if (fetchGranted) begin
                    pc <= pc + 32'd4;
                    inFlight <= 1'b1;
                end else if (fetchReturn) begin
                    inFlight <= 1'b0;
                    bufValid <= 1'b1;
                end
                if (instrTake) begin
                    bufValid <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetchGranted) begin
            instrPc <= pc;
        end
        if (fetchReturn) begin
            instr <= fetchPort.rdData;
        end
    end

    assign instrValid = bufValid;

    takeNeedsValid: assert property (@(posedge clk) disable iff (!rstN)
        instrTake |-> instrValid);
endmodule

// File: hw/memArbiter.sv
`timescale 1ns/1ps

module memArbiter (
    input  logic              clk,
    input  logic              rstN,
    memPortIf.arbiter         dataPort,
    memPortIf.arbiter         fetchPort,
    output rvPkg::word_t      memAddr,
    output rvPkg::word_t      memWrData,
    output logic              memWrEnable,
    output rvPkg::writeLen_t  memWriteLength,
    output logic              memRead,
    input  rvPkg::word_t      memRdData
);
    logic dataWins;
    logic readPending;
    logic readForData;

    // Data side always wins
    assign dataWins = dataPort.req;
    assign dataPort.grant = dataPort.req;
    assign fetchPort.grant = fetchPort.req && !dataPort.req;

    assign memAddr = dataWins ? dataPort.addr : fetchPort.addr;
    assign memWrData = dataWins ? dataPort.wrData : fetchPort.wrData;
    assign memWriteLength = dataWins ? dataPort.writeLength : fetchPort.writeLength;
    assign memWrEnable = dataWins ? dataPort.wrEnable : (fetchPort.req && fetchPort.wrEnable);
    assign memRead = dataWins ? !dataPort.wrEnable : (fetchPort.req && !fetchPort.wrEnable);

    // Owner of the read in flight
    always_ff @(posedge clk) begin
        if (!rstN) begin
            readPending <= 1'b0;
            readForData <= 1'b0;
        end else begin
            readPending <= memRead;
            readForData <= dataWins;
        end
    end

    assign dataPort.rdValid = readPending && readForData;
    assign fetchPort.rdValid = readPending && !readForData;
    assign dataPort.rdData = memRdData;
    assign fetchPort.rdData = memRdData;

    // Load data only comes back while the data side waits for it
    dataReturnWhileWaiting: assert property (@(posedge clk) disable iff (!rstN)
        dataPort.rdValid |-> !dataPort.req);
endmodule

// File: hw/rvCore.sv
`timescale 1ns/1ps

module rvCore (
    input  logic             clk,
    input  logic             rstN,
    output rvPkg::word_t     memAddr,
    output rvPkg::word_t     memWrData,
    output logic             memWrEnable,
    output rvPkg::writeLen_t memWriteLength,
    output logic             memRead,
    input  rvPkg::word_t     memRdData,
    output logic             retireValid,
    output rvPkg::word_t     retirePc,
    output rvPkg::regAddr_t  retireRd,
    output logic             retireWrite,
    output rvPkg::word_t     retireData
);
    memPortIf fetchBus ();
    memPortIf dataBus ();

    logic instrValid;
    logic instrTake;
    logic redirect;
    rvPkg::word_t instr;
    rvPkg::word_t instrPc;
    rvPkg::word_t redirectPc;

    fetchUnit fetchUnit_i (
        .clk(clk),
        .rstN(rstN),
        .fetchPort(fetchBus.requester),
        .instrValid(instrValid),
        .instr(instr),
        .instrPc(instrPc),
        .instrTake(instrTake),
        .redirect(redirect),
        .redirectPc(redirectPc)
    );

    executeStage executeStage_i (
        .clk(clk),
        .rstN(rstN),
        .dataPort(dataBus.requester),
        .instrValid(instrValid),
        .instr(instr),
        .instrPc(instrPc),
        .instrTake(instrTake),
        .redirect(redirect),
        .redirectPc(redirectPc),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireRd(retireRd),
        .retireWrite(retireWrite),
        .retireData(retireData)
    );

    memArbiter memArbiter_i (
        .clk(clk),
        .rstN(rstN),
        .dataPort(dataBus.arbiter),
        .fetchPort(fetchBus.arbiter),
        .memAddr(memAddr),
        .memWrData(memWrData),
        .memWrEnable(memWrEnable),
        .memWriteLength(memWriteLength),
        .memRead(memRead),
        .memRdData(memRdData)
    );
endmodule

// File: dv/rvCoreTb.sv
`timescale 1ns/1ps

module rvCoreTb;
    localparam int progLength = 200;
    localparam int resetCycles = 5;
    localparam int timeoutCycles = 8 * progLength + resetCycles + 50;
    localparam int memWords = 2048;
    localparam rvPkg::word_t endPc = rvPkg::word_t'(4 * (progLength - 1));

    logic clk;
    logic rstN;
    rvPkg::word_t memAddr;
    rvPkg::word_t memWrData;
    logic memWrEnable;
    rvPkg::writeLen_t memWriteLength;
    logic memRead;
    rvPkg::word_t memRdData;
    logic retireValid;
    rvPkg::word_t retirePc;
    rvPkg::regAddr_t retireRd;
    logic retireWrite;
    rvPkg::word_t retireData;

    rvPkg::word_t mem [memWords];
    rvPkg::word_t refMem [memWords];
    rvPkg::word_t refRegs [32];
    rvPkg::word_t refPc;
    logic [31:0] seed;
    int errors;
    int retired;
    int cycles;
    logic done;
    logic lastMemRead;
    rvPkg::word_t lastMemAddr;

    // What the model expects from the instruction it just stepped
    rvPkg::word_t expPc;
    logic expWrite;
    rvPkg::regAddr_t expRd;
    rvPkg::word_t expData;
    logic expStore;
    rvPkg::word_t expAddr;
    rvPkg::word_t expStoreData;
    rvPkg::writeLen_t expLen;
    logic expLoad;
    rvPkg::word_t expLoadAddr;

    rvCore rvCore_i (
        .clk(clk),
        .rstN(rstN),
        .memAddr(memAddr),
        .memWrData(memWrData),
        .memWrEnable(memWrEnable),
        .memWriteLength(memWriteLength),
        .memRead(memRead),
        .memRdData(memRdData),
        .retireValid(retireValid),
        .retirePc(retirePc),
        .retireRd(retireRd),
        .retireWrite(retireWrite),
        .retireData(retireData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int unsigned randBelow(int unsigned n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return (seed >> 8) % n;
    endfunction

    function automatic rvPkg::regAddr_t randReg();
        return rvPkg::regAddr_t'(randBelow(16));
    endfunction

    function automatic rvPkg::regAddr_t destReg();
        rvPkg::regAddr_t r;
        r = randReg();
        // x1 keeps the data base
        return (r == 5'd1) ? 5'd0 : r;
    endfunction

    function automatic rvPkg::word_t mergeStore(rvPkg::word_t old, rvPkg::word_t data,
                                                rvPkg::writeLen_t len);
        case (len)
            3'b000: return {old[31:8], data[7:0]};
            3'b001: return {old[31:16], data[15:0]};
            default: return data;
        endcase
    endfunction

    function automatic rvPkg::word_t aluModel(logic [2:0] f3, logic alt, rvPkg::word_t a,
                                              rvPkg::word_t b);
        case (f3)
            3'b000: return alt ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: return alt ? rvPkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchModel(logic [2:0] f3, rvPkg::word_t a, rvPkg::word_t b);
        case (f3)
            3'b000: return a == b;
            3'b001: return a != b;
            3'b100: return $signed(a) < $signed(b);
            3'b101: return $signed(a) >= $signed(b);
            3'b110: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic genProgram();
        rvPkg::word_t ins;
        rvPkg::regAddr_t rd;
        rvPkg::regAddr_t rs1;
        rvPkg::regAddr_t rs2;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm12;
        logic [12:0] bOff;
        logic [20:0] jOff;
        int target;
        for (int w = 0; w < memWords; w++) begin
            mem[w[10:0]] = rvPkg::word_t'(w) * 32'h9e3779b1 + 32'h3c6ef372;
        end
        // LUI x1, 1 sets the data base to 0x1000
        mem[0] = {20'h00001, 5'd1, rvPkg::opLui};
        for (int i = 1; i < progLength - 1; i++) begin
            rd = destReg();
            rs1 = randReg();
            rs2 = randReg();
            f3 = 3'(randBelow(8));
            imm12 = 12'(randBelow(4096));
            f7 = ((f3 == 3'b000 || f3 == 3'b101) && imm12[0]) ? 7'h20 : 7'h00;
            target = i + 1 + int'(randBelow(4));
            if (target > progLength - 1) begin
                target = progLength - 1;
            end
            bOff = 13'((target - i) * 4);
            jOff = 21'((target - i) * 4);
            case (randBelow(12))
                0, 1: ins = {f7, rs2, rs1, f3, rd, rvPkg::opOp};
                2, 3: begin
                    if (f3 == 3'b001) begin
                        imm12 = {7'h00, rs2};
                    end else if (f3 == 3'b101) begin
                        imm12 = {f7, rs2};
                    end
                    ins = {imm12, rs1, f3, rd, rvPkg::opOpImm};
                end
                4: ins = {20'(randBelow(1 << 20)), rd, rvPkg::opLui};
                5, 6: begin
                    imm12 = 12'(4 * randBelow(16));
                    f3 = (f3 < 3'd3) ? 3'b000 : ((f3 < 3'd6) ? 3'b100 : 3'b010);
                    ins = {imm12, 5'd1, f3, rd, rvPkg::opLoad};
                end
                7, 8: begin
                    imm12 = 12'(4 * randBelow(16));
                    f3 = (f3[1:0] == 2'b11) ? 3'b010 : {1'b0, f3[1:0]};
                    ins = {imm12[11:5], rs2, 5'd1, f3, imm12[4:0], rvPkg::opStore};
                end
                9, 10: begin
                    // No BEQ-style codes 2 and 3 in the branch space
                    if (f3[2:1] == 2'b01) begin
                        f3 = f3 ^ 3'b110;
                    end
                    ins = {bOff[12], bOff[10:5], rs2, rs1, f3, bOff[4:1], bOff[11],
                           rvPkg::opBranch};
                end
                default: ins = {jOff[20], jOff[10:1], jOff[11], jOff[19:12], rd, rvPkg::opJal};
            endcase
            mem[i[10:0]] = ins;
        end
        // JAL x0, 0 spins at the end
        mem[10'(progLength - 1)] = {25'h0, rvPkg::opJal};
        for (int w = 0; w < memWords; w++) begin
            refMem[w[10:0]] = mem[w[10:0]];
        end
        for (int r = 0; r < 32; r++) begin
            refRegs[r[4:0]] = '0;
        end
        refPc = rvPkg::resetPc;
    endtask

    task automatic stepModel();
        rvPkg::word_t ins;
        rvPkg::word_t a;
        rvPkg::word_t b;
        rvPkg::word_t immI;
        rvPkg::word_t loaded;
        rvPkg::word_t nextPc;
        logic [2:0] f3;
        logic writes;
        ins = refMem[refPc[12:2]];
        f3 = ins[14:12];
        a = refRegs[ins[19:15]];
        b = refRegs[ins[24:20]];
        immI = {{20{ins[31]}}, ins[31:20]};
        expPc = refPc;
        expRd = ins[11:7];
        expData = '0;
        expStore = 1'b0;
        expLoad = 1'b0;
        writes = 1'b1;
        nextPc = refPc + 32'd4;
        case (ins[6:0])
            rvPkg::opLui: expData = {ins[31:12], 12'h000};
            rvPkg::opJal: begin
                expData = refPc + 32'd4;
                nextPc = refPc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            rvPkg::opOpImm: expData = aluModel(f3, f3 == 3'b101 && ins[30], a, immI);
            rvPkg::opOp: expData = aluModel(f3, ins[30], a, b);
            rvPkg::opLoad: begin
                expLoad = 1'b1;
                expLoadAddr = a + immI;
                loaded = refMem[expLoadAddr[12:2]];
                case (f3)
                    3'b000: expData = {{24{loaded[7]}}, loaded[7:0]};
                    3'b100: expData = {24'h0, loaded[7:0]};
                    default: expData = loaded;
                endcase
            end
            rvPkg::opStore: begin
                writes = 1'b0;
                expStore = 1'b1;
                expAddr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                expStoreData = b;
                expLen = f3;
                refMem[expAddr[12:2]] = mergeStore(refMem[expAddr[12:2]], b, f3);
            end
            rvPkg::opBranch: begin
                writes = 1'b0;
                if (branchModel(f3, a, b)) begin
                    nextPc = refPc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            default: writes = 1'b0;
        endcase
        expWrite = writes && (expRd != 5'd0);
        if (expWrite) begin
            refRegs[expRd] = expData;
        end
        refPc = nextPc;
    endtask

    task automatic checkWord(string name, rvPkg::word_t got, rvPkg::word_t expected);
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic checkReg(string name, rvPkg::regAddr_t got, rvPkg::regAddr_t expected);
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s is x%0d, expected x%0d", $time, name, got, expected);
        end
    endtask

    task automatic checkFlag(string name, logic got, logic expected);
        if (got !== expected) begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, expected);
        end
    endtask

    task automatic checkStore(rvPkg::word_t addr, rvPkg::word_t data, rvPkg::writeLen_t len);
        if (addr !== expAddr || data !== expStoreData || len !== expLen) begin
            errors++;
            $display("error at %0t ns: store %h <= %h len %0d, expected %h <= %h len %0d",
                     $time, addr, data, len, expAddr, expStoreData, expLen);
        end
    endtask

    task automatic checkRetire();
        stepModel();
        checkWord("retirePc", retirePc, expPc);
        checkFlag("retireWrite", retireWrite, expWrite);
        checkFlag("memWrEnable", memWrEnable, expStore);
        if (expWrite) begin
            checkReg("retireRd", retireRd, expRd);
            checkWord("retireData", retireData, expData);
        end
        if (expStore) begin
            checkStore(memAddr, memWrData, memWriteLength);
        end
        // The load's read went out the cycle before it retired
        if (expLoad) begin
            checkFlag("memRead", lastMemRead, 1'b1);
            checkWord("loadAddr", lastMemAddr, expLoadAddr);
        end
        retired++;
        if (expPc == endPc) begin
            done = 1'b1;
        end
    endtask

    // One-cycle read latency, writes land by length
    task automatic serveMemory();
        if (memRead) begin
            memRdData <= mem[memAddr[12:2]];
        end
        if (memWrEnable) begin
            mem[memAddr[12:2]] = mergeStore(mem[memAddr[12:2]], memWrData, memWriteLength);
        end
    endtask

    initial begin
        rstN = 1'b0;
        memRdData = '0;
        errors = 0;
        retired = 0;
        cycles = 0;
        done = 1'b0;
        lastMemRead = 1'b0;
        lastMemAddr = '0;
        seed = 32'hb321a43f;
        genProgram();
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
        while (!done && cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
            serveMemory();
            @(negedge clk);
            if (retireValid) begin
                checkRetire();
            end
            lastMemRead = memRead;
            lastMemAddr = memAddr;
        end
        if (!done) begin
            $display("Timeout: the end loop was not reached within %0d cycles", timeoutCycles);
        end
        $display("Retired %0d instructions in %0d cycles with %0d errors",
                 retired, cycles, errors);
        if (errors == 0 && done) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end
endmodule

// File: tb.f
hw/rvPkg.sv
hw/memPortIf.sv
hw/controlUnit.sv
hw/alu.sv
hw/registerFile.sv
hw/executeStage.sv
hw/fetchUnit.sv
hw/memArbiter.sv
hw/rvCore.sv
dv/rvCoreTb.sv

// File: run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module rvCoreTb -o rvCoreSim
buildStatus=$?
if [ $buildStatus -ne 0 ]; then
    echo "Verilator build failed with status $buildStatus"
    exit 1
fi

./obj_dir/rvCoreSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

grep -qx "Result: PASSED" sim.log
grepStatus=$?
if [ $grepStatus -ne 0 ]; then
    echo "Pass message not found in sim.log"
    exit 1
fi
exit 0
